// ==== Bender.yml ====
package:
  name: fsync_node_2d

sources:
  - include_dirs:
      - include
    files:
      - verilog/fsync_pkg.sv
      - verilog/fsync_stream_if.sv
      - verilog/fsync_rx_fifo.sv
      - verilog/fsync_arbiter.sv
      - verilog/fsync_aggregator.sv
      - verilog/fsync_tx_port.sv
      - verilog/fsync_node_2d.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/fsync_node_assert.sv
      - sim/fsync_checker.sv
      - sim/tb_fsync_node_2d.sv

// ==== files.f ====
+incdir+include
verilog/fsync_pkg.sv
verilog/fsync_stream_if.sv
verilog/fsync_rx_fifo.sv
verilog/fsync_arbiter.sv
verilog/fsync_aggregator.sv
verilog/fsync_tx_port.sv
verilog/fsync_node_2d.sv
sim/fsync_node_assert.sv
sim/fsync_checker.sv
sim/tb_fsync_node_2d.sv

// ==== include/fsync_consts.svh ====
/*
 * Barrier synchronization node constants
 * Field widths, node level and queue depth
 */

`ifndef FSYNC_CONSTS_SVH
`define FSYNC_CONSTS_SVH

// Level field width
`define FSYNC_LVL_W 4

// Barrier id width, 16 ids
`define FSYNC_ID_W 4

// Level at which this node is the root
`define FSYNC_NODE_LVL 1

// Receive FIFO and transmit queue entries, power of two
`define FSYNC_FIFO_DEPTH 4

`endif

// ==== sim/fsync_checker.sv ====
/*
 * Response checker for the barrier node testbench
 * Matches observed responses and up requests against expected multisets
 */

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_checker (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic [1:0][1:0]           rsp_i,
  input fsync_pkg::id_t [1:0][1:0] rsp_id_i,
  input logic [1:0]                up_req_i,
  input fsync_pkg::lvl_t [1:0]     up_lvl_i,
  input fsync_pkg::id_t [1:0]      up_id_i
);
  import fsync_pkg::*;

  localparam int unsigned N_IDS = 1 << `FSYNC_ID_W;

  int              exp_rsp [2][2][N_IDS];  // Per direction, child and id
  int              exp_up  [2][N_IDS];
  lvl_t            exp_lvl [2][N_IDS];
  int              pending [2];  // Transfers still owed per direction
  int              errors;
  logic [1:0][1:0] rsp_q;
  logic [1:0]      up_q;

  task automatic expect_rsp(input int d, input id_t id, input bit from_parent);
    exp_rsp[d][0][id]++;
    exp_rsp[d][1][id]++;
    if (!from_parent) pending[d] += 2;
  endtask

  // A forwarded pair also owes the two responses the parent brings back
  task automatic expect_up(input int d, input lvl_t lvl, input id_t id);
    exp_up[d][id]++;
    exp_lvl[d][id] = lvl;
    pending[d] += 3;
  endtask

  task automatic take_rsp(input int d, input int c, input id_t id);
    if (exp_rsp[d][c][id] == 0) begin
      errors++;
      $display("Error at %0t: unexpected response to %s child %0d with id %0d",
               $time, d ? "v" : "h", c, id);
    end else begin
      exp_rsp[d][c][id]--;
      pending[d]--;
    end
  endtask

  task automatic take_up(input int d, input lvl_t lvl, input id_t id);
    if (exp_up[d][id] == 0) begin
      errors++;
      $display("Error at %0t: unexpected %s up request with id %0d", $time, d ? "v" : "h", id);
    end else begin
      exp_up[d][id]--;
      pending[d]--;
      if (lvl != exp_lvl[d][id]) begin
        errors++;
        $display("Error at %0t: %s up request id %0d has level %0d, expected %0d",
                 $time, d ? "v" : "h", id, lvl, exp_lvl[d][id]);
      end
    end
  endtask

  task automatic check_drained();
    for (int d = 0; d < 2; d++) begin
      for (int id = 0; id < N_IDS; id++) begin
        if (exp_up[d][id] != 0) begin
          errors++;
          $display("Error at %0t: %s up request for id %0d never seen", $time, d ? "v" : "h", id);
        end
        for (int c = 0; c < 2; c++) begin
          if (exp_rsp[d][c][id] != 0) begin
            errors++;
            $display("Error at %0t: %s child %0d missed response for id %0d",
                     $time, d ? "v" : "h", c, id);
          end
        end
      end
    end
  endtask

  // New transfer when req is seen rising, outputs are stable here
  always @(negedge clk_i) begin
    if (rst_ni) begin
      for (int d = 0; d < 2; d++) begin
        for (int c = 0; c < 2; c++) begin
          if (rsp_i[d][c] && !rsp_q[d][c]) take_rsp(d, c, rsp_id_i[d][c]);
        end
        if (up_req_i[d] && !up_q[d]) take_up(d, up_lvl_i[d], up_id_i[d]);
      end
    end
    rsp_q = rsp_i;
    up_q  = up_req_i;
  end

endmodule

// ==== sim/fsync_node_assert.sv ====
/*
 * Protocol assertions for the barrier node
 * Four-phase rules on every external channel and legal request levels
 */

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_node_assert (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic [1:0]            h_req_i,
  input fsync_pkg::lvl_t [1:0] h_req_lvl_i,
  input logic [1:0]            h_req_ack_o,
  input logic [1:0]            h_rsp_o,
  input fsync_pkg::id_t [1:0]  h_rsp_id_o,
  input logic [1:0]            h_rsp_ack_i,
  input logic                  h_up_req_o,
  input fsync_pkg::id_t        h_up_id_o,
  input logic                  h_up_ack_i,
  input logic                  h_dn_req_i,
  input logic                  h_dn_ack_o,
  input logic [1:0]            v_req_i,
  input fsync_pkg::lvl_t [1:0] v_req_lvl_i,
  input logic [1:0]            v_req_ack_o,
  input logic [1:0]            v_rsp_o,
  input fsync_pkg::id_t [1:0]  v_rsp_id_o,
  input logic [1:0]            v_rsp_ack_i,
  input logic                  v_up_req_o,
  input fsync_pkg::id_t        v_up_id_o,
  input logic                  v_up_ack_i,
  input logic                  v_dn_req_i,
  input logic                  v_dn_ack_o
);
  import fsync_pkg::*;

  logic [5:0]     rx_req;  // Channels where the node receives
  logic [5:0]     rx_ack;
  logic [5:0]     tx_req;  // Channels where the node sends
  logic [5:0]     tx_ack;
  id_t [5:0]      tx_id;
  int             fails;   // Failed assertions so far

  assign rx_req = {v_dn_req_i, v_req_i, h_dn_req_i, h_req_i};
  assign rx_ack = {v_dn_ack_o, v_req_ack_o, h_dn_ack_o, h_req_ack_o};
  assign tx_req = {v_up_req_o, v_rsp_o, h_up_req_o, h_rsp_o};
  assign tx_ack = {v_up_ack_i, v_rsp_ack_i, h_up_ack_i, h_rsp_ack_i};
  assign tx_id  = {v_up_id_o, v_rsp_id_o, h_up_id_o, h_rsp_id_o};

  // Edges are seen one clock late, so the partner is checked at the causing edge
  for (genvar i = 0; i < 6; i++) begin : gen_chan
    a_rx_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(rx_ack[i]) |-> $past(rx_req[i])) else begin
      fails++;
      $error("Ack rose without req, rx channel %0d", i);
    end
    a_rx_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $fell(rx_ack[i]) |-> !$past(rx_req[i])) else begin
      fails++;
      $error("Ack fell while req high, rx channel %0d", i);
    end
    a_tx_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tx_req[i] && !tx_ack[i] |=> tx_req[i] && $stable(tx_id[i])) else begin
      fails++;
      $error("Req or id changed before ack, tx channel %0d", i);
    end
    a_tx_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(tx_req[i]) |-> !$past(tx_ack[i])) else begin
      fails++;
      $error("Req rose before ack fell, tx channel %0d", i);
    end
  end

  for (genvar c = 0; c < 2; c++) begin : gen_lvl
    a_h_lvl: assert property (@(posedge clk_i) disable iff (!rst_ni)
      h_req_i[c] |-> h_req_lvl_i[c] >= lvl_t'(`FSYNC_NODE_LVL)) else begin
      fails++;
      $error("Request level below node level, h child %0d", c);
    end
    a_v_lvl: assert property (@(posedge clk_i) disable iff (!rst_ni)
      v_req_i[c] |-> v_req_lvl_i[c] >= lvl_t'(`FSYNC_NODE_LVL)) else begin
      fails++;
      $error("Request level below node level, v child %0d", c);
    end
  end

endmodule

// ==== sim/tb_fsync_node_2d.sv ====
/*
 * Testbench for the two-direction barrier node
 * Four-phase child and parent traffic, root and forwarded barriers
 */

`timescale 1ns/1ps
`include "fsync_consts.svh"

module tb_fsync_node_2d;
  import fsync_pkg::*;

  localparam int unsigned N_IDS       = 1 << `FSYNC_ID_W;
  localparam int          N_MIX       = 6;
  localparam int          N_CONC      = 5;
  localparam int          CONC_ROUNDS = 4;
  localparam int          N_BARRIERS  = 2 + 2 * N_MIX + 2 * N_CONC * CONC_ROUNDS;
  localparam int          MAX_CYCLES  = 300 * N_BARRIERS + 1000;

  logic            clk_i;
  logic            rst_ni;
  logic [1:0][1:0] req;  // First index is the direction, 0 for h
  lvl_t [1:0][1:0] req_lvl;
  id_t  [1:0][1:0] req_id;
  logic [1:0][1:0] req_ack;
  logic [1:0][1:0] rsp;
  id_t  [1:0][1:0] rsp_id;
  logic [1:0][1:0] rsp_ack;
  logic [1:0]      up_req;
  lvl_t [1:0]      up_lvl;
  id_t  [1:0]      up_id;
  logic [1:0]      up_ack;
  logic [1:0]      dn_req;
  id_t  [1:0]      dn_id;
  logic [1:0]      dn_ack;

  logic [1:0] seen   [2][N_IDS];  // Arrived children per id
  lvl_t       lvl_of [2][N_IDS];
  id_t        ord    [2][2][N_IDS];
  int         n_ids  [2];
  int         errors;
  int         cycles = 0;

  fsync_node_2d i_fsync_node_2d (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .h_req_i     ( req[0]     ),
    .h_req_lvl_i ( req_lvl[0] ),
    .h_req_id_i  ( req_id[0]  ),
    .h_req_ack_o ( req_ack[0] ),
    .h_rsp_o     ( rsp[0]     ),
    .h_rsp_id_o  ( rsp_id[0]  ),
    .h_rsp_ack_i ( rsp_ack[0] ),
    .h_up_req_o  ( up_req[0]  ),
    .h_up_lvl_o  ( up_lvl[0]  ),
    .h_up_id_o   ( up_id[0]   ),
    .h_up_ack_i  ( up_ack[0]  ),
    .h_dn_req_i  ( dn_req[0]  ),
    .h_dn_id_i   ( dn_id[0]   ),
    .h_dn_ack_o  ( dn_ack[0]  ),
    .v_req_i     ( req[1]     ),
    .v_req_lvl_i ( req_lvl[1] ),
    .v_req_id_i  ( req_id[1]  ),
    .v_req_ack_o ( req_ack[1] ),
    .v_rsp_o     ( rsp[1]     ),
    .v_rsp_id_o  ( rsp_id[1]  ),
    .v_rsp_ack_i ( rsp_ack[1] ),
    .v_up_req_o  ( up_req[1]  ),
    .v_up_lvl_o  ( up_lvl[1]  ),
    .v_up_id_o   ( up_id[1]   ),
    .v_up_ack_i  ( up_ack[1]  ),
    .v_dn_req_i  ( dn_req[1]  ),
    .v_dn_id_i   ( dn_id[1]   ),
    .v_dn_ack_o  ( dn_ack[1]  )
  );

  bind fsync_node_2d fsync_node_assert i_node_assert (.*);

  fsync_checker i_checker (
    .clk_i    ( clk_i  ),
    .rst_ni   ( rst_ni ),
    .rsp_i    ( rsp    ),
    .rsp_id_i ( rsp_id ),
    .up_req_i ( up_req ),
    .up_lvl_i ( up_lvl ),
    .up_id_i  ( up_id  )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles with barriers still open", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // 1 when a complete pair goes to the parent, 0 when it completes here
  function automatic bit expect_barrier(input lvl_t lvl);
    return lvl > lvl_t'(`FSYNC_NODE_LVL);
  endfunction

  task automatic note_arrival(input int d, input int c, input lvl_t lvl, input id_t id);
    seen[d][id][c] = 1'b1;
    if (&seen[d][id]) begin
      seen[d][id] = 2'b00;
      if (expect_barrier(lvl)) i_checker.expect_up(d, lvl, id);
      else i_checker.expect_rsp(d, id, 1'b0);
    end
  endtask

  task automatic send_req(input int d, input int c, input lvl_t lvl, input id_t id);
    req_lvl[d][c] = lvl;
    req_id[d][c]  = id;
    req[d][c]     = 1'b1;
    @(negedge clk_i);
    while (!req_ack[d][c]) @(negedge clk_i);
    note_arrival(d, c, lvl, id);
    req[d][c] = 1'b0;
    while (req_ack[d][c]) @(negedge clk_i);
  endtask

  task automatic respond_rsp(input int d, input int c);
    forever begin
      @(negedge clk_i);
      if (rsp[d][c]) begin
        repeat ($urandom_range(0, 5)) @(negedge clk_i);
        rsp_ack[d][c] = 1'b1;
        while (rsp[d][c]) @(negedge clk_i);
        rsp_ack[d][c] = 1'b0;
      end
    end
  endtask

  // Parent model, acks the up request and later answers with the same id
  task automatic respond_up(input int d);
    id_t id;
    forever begin
      @(negedge clk_i);
      if (up_req[d]) begin
        id = up_id[d];
        repeat ($urandom_range(0, 5)) @(negedge clk_i);
        up_ack[d] = 1'b1;
        while (up_req[d]) @(negedge clk_i);
        up_ack[d] = 1'b0;
        repeat ($urandom_range(1, 8)) @(negedge clk_i);
        dn_id[d]  = id;
        dn_req[d] = 1'b1;
        @(negedge clk_i);
        while (!dn_ack[d]) @(negedge clk_i);
        i_checker.expect_rsp(d, id, 1'b1);
        dn_req[d] = 1'b0;
        while (dn_ack[d]) @(negedge clk_i);
      end
    end
  endtask

  // Mode 0 root only, 1 forwarded at level 3, 2 mixed levels
  task automatic build_round(input int d, input int n, input int mode);
    id_t pool [N_IDS];
    id_t tmp;
    int  j;
    for (int i = 0; i < N_IDS; i++) pool[i] = id_t'(i);
    for (int i = N_IDS - 1; i > 0; i--) begin
      j       = $urandom_range(0, i);
      tmp     = pool[i];
      pool[i] = pool[j];
      pool[j] = tmp;
    end
    n_ids[d] = n;
    for (int i = 0; i < n; i++) begin
      if (mode == 0) lvl_of[d][pool[i]] = lvl_t'(`FSYNC_NODE_LVL);
      else if (mode == 1) lvl_of[d][pool[i]] = lvl_t'(3);
      else if ($urandom_range(0, 1)) lvl_of[d][pool[i]] = lvl_t'(`FSYNC_NODE_LVL);
      else lvl_of[d][pool[i]] = lvl_t'(`FSYNC_NODE_LVL + $urandom_range(1, 3));
      ord[d][0][i] = pool[i];
      ord[d][1][i] = pool[i];
    end
    for (int c = 0; c < 2; c++) begin  // Own arrival order per child
      for (int i = n - 1; i > 0; i--) begin
        j            = $urandom_range(0, i);
        tmp          = ord[d][c][i];
        ord[d][c][i] = ord[d][c][j];
        ord[d][c][j] = tmp;
      end
    end
  endtask

  task automatic child_seq(input int d, input int c);
    for (int i = 0; i < n_ids[d]; i++) begin
      repeat ($urandom_range(0, 3)) @(negedge clk_i);
      send_req(d, c, lvl_of[d][ord[d][c][i]], ord[d][c][i]);
    end
  endtask

  // Ids come back only after every owed transfer of the round is seen
  task automatic run_round(input int d, input int n, input int mode);
    build_round(d, n, mode);
    fork
      child_seq(d, 0);
      child_seq(d, 1);
    join
    while (i_checker.pending[d] != 0) @(negedge clk_i);
  endtask

  task automatic check_idle();
    repeat (8) begin
      @(negedge clk_i);
      if (|req_ack || |rsp || |up_req || |dn_ack) begin
        errors++;
        $display("Error at %0t: handshake output active after reset", $time);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hf001dbaa));
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    req     = '0;
    req_lvl = '0;
    req_id  = '0;
    rsp_ack = '0;
    up_ack  = '0;
    dn_req  = '0;
    dn_id   = '0;
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < N_IDS; i++) seen[d][i] = 2'b00;
    end
    fork
      respond_rsp(0, 0);
      respond_rsp(0, 1);
      respond_rsp(1, 0);
      respond_rsp(1, 1);
      respond_up(0);
      respond_up(1);
    join_none
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    check_idle();
    run_round(0, 1, 0);
    run_round(1, 1, 1);
    run_round(0, N_MIX, 2);
    run_round(1, N_MIX, 2);
    repeat (CONC_ROUNDS) begin
      fork
        run_round(0, N_CONC, 2);
        run_round(1, N_CONC, 2);
      join
    end
    repeat (20) @(negedge clk_i);
    i_checker.check_drained();
    $display("Done: %0d testbench errors, %0d checker errors, %0d assertion failures",
             errors, i_checker.errors, i_fsync_node_2d.i_node_assert.fails);
    if (errors == 0 && i_checker.errors == 0 && i_fsync_node_2d.i_node_assert.fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== verilog/fsync_aggregator.sv ====
/*
 * Barrier aggregation for one direction
 * Tracks child arrivals per id, completes root barriers locally,
 * forwards higher levels to the parent and sends parent responses down
 */

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_aggregator (
  input  logic        clk_i,
  input  logic        rst_ni,
  fsync_stream_if.dst req_i,
  input  logic        src_i,
  fsync_stream_if.dst parent_rsp_i,
  fsync_stream_if.src up_o,
  fsync_stream_if.src down_o
);
  import fsync_pkg::*;

  localparam int unsigned N_IDS = 1 << `FSYNC_ID_W;

  arrive_t arrive_q [N_IDS];
  arrive_t arrive_new;
  logic    pair_done;
  logic    is_root;
  logic    req_fire;
  logic    rsp_fire;
  logic    root_done;
  logic    fwd_done;
  logic    up_valid_q;
  lvl_t    up_lvl_q;
  id_t     up_id_q;
  logic    dn_valid_q;
  id_t     dn_id_q;

  assign arrive_new = arrive_q[req_i.id] | (src_i ? arrive_t'(2'b10) : arrive_t'(2'b01));
  assign pair_done  = &arrive_new;
  assign is_root    = (req_i.lvl == lvl_t'(`FSYNC_NODE_LVL));

  // Parent responses own the down path, requests wait for both slots
  assign req_i.ready        = !up_valid_q && !dn_valid_q && !parent_rsp_i.valid;
  assign parent_rsp_i.ready = !dn_valid_q;

  assign req_fire  = req_i.valid && req_i.ready;
  assign rsp_fire  = parent_rsp_i.valid && parent_rsp_i.ready;
  assign root_done = req_fire && pair_done && is_root;
  assign fwd_done  = req_fire && pair_done && !is_root;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      arrive_q <= '{default: '0};
    end else if (req_fire) begin
      arrive_q[req_i.id] <= pair_done ? arrive_t'('0) : arrive_new;  // Free id on completion
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      up_valid_q <= 1'b0;
      dn_valid_q <= 1'b0;
    end else begin
      if (up_valid_q && up_o.ready)   up_valid_q <= 1'b0;
      if (fwd_done)                   up_valid_q <= 1'b1;
      if (dn_valid_q && down_o.ready) dn_valid_q <= 1'b0;
      if (rsp_fire || root_done)      dn_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_done) begin
      up_lvl_q <= req_i.lvl;
      up_id_q  <= req_i.id;
    end
    if (rsp_fire) begin
      dn_id_q <= parent_rsp_i.id;
    end else if (root_done) begin
      dn_id_q <= req_i.id;
    end
  end

  assign up_o.valid = up_valid_q;
  assign up_o.lvl   = up_lvl_q;
  assign up_o.id    = up_id_q;

  assign down_o.valid = dn_valid_q;
  assign down_o.lvl   = lvl_t'(`FSYNC_NODE_LVL);  // Children only use the id
  assign down_o.id    = dn_id_q;

endmodule

// ==== verilog/fsync_arbiter.sv ====
/*
 * Round-robin merge of the two child request streams
 * Tags the granted entry with its child index
 */

`timescale 1ns/1ps

module fsync_arbiter (
  input  logic        clk_i,
  input  logic        rst_ni,
  fsync_stream_if.dst in0_i,
  fsync_stream_if.dst in1_i,
  fsync_stream_if.src out_o,
  output logic        src_o
);

  logic prio_q;    // Child favoured on contention
  logic any_valid;
  logic sel;

  assign any_valid = in0_i.valid || in1_i.valid;
  assign sel       = (in0_i.valid && in1_i.valid) ? prio_q : in1_i.valid;

  assign out_o.valid = any_valid;
  assign out_o.lvl   = sel ? in1_i.lvl : in0_i.lvl;
  assign out_o.id    = sel ? in1_i.id  : in0_i.id;
  assign src_o       = sel;

  assign in0_i.ready = out_o.ready && !sel;
  assign in1_i.ready = out_o.ready && sel;

  // A stalled grant is pinned so the output entry stays stable
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= 1'b0;
    end else if (any_valid) begin
      prio_q <= out_o.ready ? !sel : sel;  // Toggle away from the winner
    end
  end

endmodule

// ==== verilog/fsync_node_2d.sv ====
/*
 * Two-direction barrier synchronization node
 * Each direction merges two children, completes root barriers locally
 * and forwards higher-level barriers to its parent over four-phase links
 */

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_node_2d (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [1:0]            h_req_i,
  input  fsync_pkg::lvl_t [1:0] h_req_lvl_i,
  input  fsync_pkg::id_t [1:0]  h_req_id_i,
  output logic [1:0]            h_req_ack_o,
  output logic [1:0]            h_rsp_o,
  output fsync_pkg::id_t [1:0]  h_rsp_id_o,
  input  logic [1:0]            h_rsp_ack_i,
  output logic                  h_up_req_o,
  output fsync_pkg::lvl_t       h_up_lvl_o,
  output fsync_pkg::id_t        h_up_id_o,
  input  logic                  h_up_ack_i,
  input  logic                  h_dn_req_i,
  input  fsync_pkg::id_t        h_dn_id_i,
  output logic                  h_dn_ack_o,
  input  logic [1:0]            v_req_i,
  input  fsync_pkg::lvl_t [1:0] v_req_lvl_i,
  input  fsync_pkg::id_t [1:0]  v_req_id_i,
  output logic [1:0]            v_req_ack_o,
  output logic [1:0]            v_rsp_o,
  output fsync_pkg::id_t [1:0]  v_rsp_id_o,
  input  logic [1:0]            v_rsp_ack_i,
  output logic                  v_up_req_o,
  output fsync_pkg::lvl_t       v_up_lvl_o,
  output fsync_pkg::id_t        v_up_id_o,
  input  logic                  v_up_ack_i,
  input  logic                  v_dn_req_i,
  input  fsync_pkg::id_t        v_dn_id_i,
  output logic                  v_dn_ack_o
);
  import fsync_pkg::*;

  // First index is the direction, 0 for h and 1 for v
  logic c_req [2][2];
  lvl_t c_lvl [2][2];
  id_t  c_id  [2][2];
  logic c_ack [2][2];
  logic r_req [2][2];
  id_t  r_id  [2][2];
  logic r_ack [2][2];
  logic up_req [2];
  lvl_t up_lvl [2];
  id_t  up_id  [2];
  logic up_ack [2];
  logic dn_req [2];
  id_t  dn_id  [2];
  logic dn_ack [2];

  for (genvar c = 0; c < 2; c++) begin : gen_map
    assign c_req[0][c] = h_req_i[c];
    assign c_req[1][c] = v_req_i[c];
    assign c_lvl[0][c] = h_req_lvl_i[c];
    assign c_lvl[1][c] = v_req_lvl_i[c];
    assign c_id[0][c]  = h_req_id_i[c];
    assign c_id[1][c]  = v_req_id_i[c];
    assign r_ack[0][c] = h_rsp_ack_i[c];
    assign r_ack[1][c] = v_rsp_ack_i[c];
  end

  assign h_req_ack_o = {c_ack[0][1], c_ack[0][0]};
  assign v_req_ack_o = {c_ack[1][1], c_ack[1][0]};
  assign h_rsp_o     = {r_req[0][1], r_req[0][0]};
  assign v_rsp_o     = {r_req[1][1], r_req[1][0]};
  assign h_rsp_id_o  = {r_id[0][1], r_id[0][0]};
  assign v_rsp_id_o  = {r_id[1][1], r_id[1][0]};

  assign up_ack[0]  = h_up_ack_i;
  assign up_ack[1]  = v_up_ack_i;
  assign h_up_req_o = up_req[0];
  assign v_up_req_o = up_req[1];
  assign h_up_lvl_o = up_lvl[0];
  assign v_up_lvl_o = up_lvl[1];
  assign h_up_id_o  = up_id[0];
  assign v_up_id_o  = up_id[1];

  assign dn_req[0]  = h_dn_req_i;
  assign dn_req[1]  = v_dn_req_i;
  assign dn_id[0]   = h_dn_id_i;
  assign dn_id[1]   = v_dn_id_i;
  assign h_dn_ack_o = dn_ack[0];
  assign v_dn_ack_o = dn_ack[1];

  for (genvar d = 0; d < 2; d++) begin : gen_dir
    fsync_stream_if child_s [2] ();
    fsync_stream_if tx_s [2] ();
    fsync_stream_if arb_s ();
    fsync_stream_if par_s ();
    fsync_stream_if up_s ();
    fsync_stream_if dn_s ();
    logic           arb_src;

    for (genvar c = 0; c < 2; c++) begin : gen_child
      fsync_rx_fifo i_rx (
        .clk_i  ( clk_i       ),
        .rst_ni ( rst_ni      ),
        .req_i  ( c_req[d][c] ),
        .lvl_i  ( c_lvl[d][c] ),
        .id_i   ( c_id[d][c]  ),
        .ack_o  ( c_ack[d][c] ),
        .out_o  ( child_s[c]  )
      );

      // Both child queues enqueue on the same down transfer
      assign tx_s[c].valid = dn_s.valid && tx_s[1-c].ready;
      assign tx_s[c].lvl   = dn_s.lvl;
      assign tx_s[c].id    = dn_s.id;

      fsync_tx_port i_tx (
        .clk_i  ( clk_i       ),
        .rst_ni ( rst_ni      ),
        .in_i   ( tx_s[c]     ),
        .req_o  ( r_req[d][c] ),
        .lvl_o  (             ),
        .id_o   ( r_id[d][c]  ),
        .ack_i  ( r_ack[d][c] )
      );
    end

    assign dn_s.ready = tx_s[0].ready && tx_s[1].ready;

    fsync_arbiter i_arb (
      .clk_i  ( clk_i      ),
      .rst_ni ( rst_ni     ),
      .in0_i  ( child_s[0] ),
      .in1_i  ( child_s[1] ),
      .out_o  ( arb_s      ),
      .src_o  ( arb_src    )
    );

    fsync_rx_fifo i_par_rx (
      .clk_i  ( clk_i                         ),
      .rst_ni ( rst_ni                        ),
      .req_i  ( dn_req[d]                     ),
      .lvl_i  ( lvl_t'(`FSYNC_NODE_LVL + 1)   ),  // Parent responses carry no level
      .id_i   ( dn_id[d]                      ),
      .ack_o  ( dn_ack[d]                     ),
      .out_o  ( par_s                         )
    );

    fsync_aggregator i_agg (
      .clk_i        ( clk_i   ),
      .rst_ni       ( rst_ni  ),
      .req_i        ( arb_s   ),
      .src_i        ( arb_src ),
      .parent_rsp_i ( par_s   ),
      .up_o         ( up_s    ),
      .down_o       ( dn_s    )
    );

    fsync_tx_port i_up_tx (
      .clk_i  ( clk_i     ),
      .rst_ni ( rst_ni    ),
      .in_i   ( up_s      ),
      .req_o  ( up_req[d] ),
      .lvl_o  ( up_lvl[d] ),
      .id_o   ( up_id[d]  ),
      .ack_i  ( up_ack[d] )
    );
  end

endmodule

// ==== verilog/fsync_pkg.sv ====
/*
 * Barrier synchronization node types
 * Request fields, arrival mask and handshake states
 */

package fsync_pkg;

  `include "fsync_consts.svh"

  typedef logic [`FSYNC_LVL_W-1:0] lvl_t;  // Request level
  typedef logic [`FSYNC_ID_W-1:0]  id_t;   // Barrier id
  typedef logic [1:0]              arrive_t; // One bit per child

  // Four-phase states, rx uses the first three and tx the last two
  typedef enum logic [2:0] {
    HS_IDLE,
    HS_ACK,
    HS_WAIT_LOW,
    HS_REQ,
    HS_DROP
  } hs_state_e;

endpackage

// ==== verilog/fsync_rx_fifo.sv ====
/*
 * Four-phase receiver with circular FIFO
 * Captures level and id on req, acks, and presents the head as a stream
 */

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_rx_fifo (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  fsync_pkg::lvl_t lvl_i,
  input  fsync_pkg::id_t  id_i,
  output logic            ack_o,
  fsync_stream_if.src     out_o
);
  import fsync_pkg::*;

  localparam int unsigned PTR_W = $clog2(`FSYNC_FIFO_DEPTH);

  hs_state_e      state_q;
  hs_state_e      state_d;
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;
  lvl_t           lvl_mem [`FSYNC_FIFO_DEPTH];
  id_t            id_mem  [`FSYNC_FIFO_DEPTH];
  logic           full;
  logic           empty;
  logic           capture;
  logic           commit;
  logic           pop;

  assign empty   = (wr_ptr_q == rd_ptr_q);
  assign full    = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                   (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign capture = (state_q == HS_IDLE) && req_i && !full; // Ack held off while full
  assign commit  = (state_q == HS_ACK);  // Entry becomes visible one cycle after ack
  assign pop     = out_o.ready && !empty;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      HS_IDLE:     if (capture) state_d = HS_ACK;
      HS_ACK:      state_d = req_i ? HS_WAIT_LOW : HS_IDLE;
      HS_WAIT_LOW: if (!req_i) state_d = HS_IDLE;
      default:     state_d = HS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= HS_IDLE;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (commit) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      lvl_mem[wr_ptr_q[PTR_W-1:0]] <= lvl_i;
      id_mem[wr_ptr_q[PTR_W-1:0]]  <= id_i;
    end
  end

  assign ack_o = (state_q == HS_ACK) || (state_q == HS_WAIT_LOW);

  assign out_o.valid = !empty;
  assign out_o.lvl   = lvl_mem[rd_ptr_q[PTR_W-1:0]];
  assign out_o.id    = id_mem[rd_ptr_q[PTR_W-1:0]];

endmodule

// ==== verilog/fsync_stream_if.sv ====
/*
 * Valid/ready stream between internal node blocks
 * Carries one request level and barrier id per transfer
 */

`timescale 1ns/1ps

interface fsync_stream_if;
  import fsync_pkg::*;

  logic valid;
  logic ready;
  lvl_t lvl;
  id_t  id;

  modport src (
    output valid,
    output lvl,
    output id,
    input  ready
  );

  modport dst (
    input  valid,
    input  lvl,
    input  id,
    output ready
  );

endinterface

// ==== verilog/fsync_tx_port.sv ====
/*
 * Transmit queue with four-phase sender
 * Drives one child response channel or the parent request channel
 */

`timescale 1ns/1ps
`include "fsync_consts.svh"

module fsync_tx_port (
  input  logic            clk_i,
  input  logic            rst_ni,
  fsync_stream_if.dst     in_i,
  output logic            req_o,
  output fsync_pkg::lvl_t lvl_o,
  output fsync_pkg::id_t  id_o,
  input  logic            ack_i
);
  import fsync_pkg::*;

  localparam int unsigned PTR_W = $clog2(`FSYNC_FIFO_DEPTH);

  hs_state_e      state_q;
  hs_state_e      state_d;
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;
  lvl_t           lvl_mem [`FSYNC_FIFO_DEPTH];
  id_t            id_mem  [`FSYNC_FIFO_DEPTH];
  logic           full;
  logic           empty;
  logic           push;
  logic           pop;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                 (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign push  = in_i.valid && !full;
  assign pop   = (state_q == HS_REQ) && ack_i;  // Req drops on the same edge

  assign in_i.ready = !full;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      HS_IDLE: if (!empty) state_d = HS_REQ;
      HS_REQ:  if (ack_i) state_d = HS_DROP;
      HS_DROP: if (!ack_i) state_d = HS_IDLE;  // Wait for ack low before next req
      default: state_d = HS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= HS_IDLE;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      lvl_mem[wr_ptr_q[PTR_W-1:0]] <= in_i.lvl;
      id_mem[wr_ptr_q[PTR_W-1:0]]  <= in_i.id;
    end
  end

  assign req_o = (state_q == HS_REQ);
  assign lvl_o = lvl_mem[rd_ptr_q[PTR_W-1:0]];
  assign id_o  = id_mem[rd_ptr_q[PTR_W-1:0]];

endmodule
